//--- build.f
hw/axi_bram_pkg.sv
hw/bram_1rwm.sv
hw/axi_burst_addr.sv
hw/axi_bram_ctrl.sv
hw/axi_bram.sv
tb/axi_bram_checker.sv
tb/axi_bram_tb.sv

//--- Makefile
# Verilator build and run for the AXI block RAM testbench

VERILATOR ?= verilator
TOP       ?= axi_bram_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/$(TOP)

.PHONY: all run check clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb/axi_bram_tb.sv
`timescale 1ns/1ps
`default_nettype none

module axi_bram_tb;
    import axi_bram_pkg::*;

    localparam int depth          = 1024;
    localparam int mem_bytes      = depth * 4;
    localparam int timeout_cycles = 200;

    // Channel selectors for handshake_wait
    localparam int ch_aw = 0;
    localparam int ch_w  = 1;
    localparam int ch_b  = 2;
    localparam int ch_ar = 3;
    localparam int ch_r  = 4;

    logic    clk;
    logic    rst_n;
    logic    aw_valid;
    logic    aw_ready;
    axi_aw_t aw;
    logic    w_valid;
    logic    w_ready;
    axi_w_t  w;
    logic    b_valid;
    logic    b_ready;
    axi_b_t  b;
    logic    ar_valid;
    logic    ar_ready;
    axi_ar_t ar;
    logic    r_valid;
    logic    r_ready;
    axi_r_t  r;

    // Byte-wide reference copy of the memory
    logic [7:0] model_mem [mem_bytes];

    axi_bram #(
        .DEPTH (depth)
    ) axi_bram_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw       (aw),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w        (w),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b        (b),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r)
    );

    axi_bram_checker checker_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .b_valid (b_valid),
        .b_ready (b_ready),
        .b       (b),
        .r_valid (r_valid),
        .r_ready (r_ready),
        .r       (r)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] model_word(input logic [31:0] a);
        logic [11:0] base;
        base = {a[11:2], 2'b00};
        return {model_mem[base + 12'd3], model_mem[base + 12'd2],
                model_mem[base + 12'd1], model_mem[base]};
    endfunction

    // WRAP stays inside the block of (len+1) words that holds the address
    function automatic logic [31:0] next_beat_addr(input logic [31:0] a, input int len,
                                                   input logic [1:0] kind);
        logic [31:0] span;
        logic [31:0] base;
        span = 32'((len + 1) * 4);
        if (kind == burst_wrap) begin
            base = a - (a % span);
            return base + ((a - base + 32'd4) % span);
        end
        return a + 32'd4;
    endfunction

    function automatic logic [31:0] random_addr();
        return {20'd0, 10'($urandom_range(depth - 1, 0)), 2'b00};
    endfunction

    task automatic abort_run(input string what);
        $display("Timeout while waiting for %s in test %s", what, checker_i.test_name);
        $display("Checks: %0d, errors: %0d", checker_i.checks, checker_i.errors);
        $display("Testbench failed");
        $finish;
    endtask

    // Starts and ends 2 ns after a rising edge
    task automatic handshake_wait(input int ch, input bit bp, input string what);
        bit hs;
        int n;
        hs = 1'b0;
        n  = 0;
        while (!hs && n < timeout_cycles) begin
            if (ch == ch_b) begin
                b_ready = bp ? 1'($urandom_range(1, 0)) : 1'b1;
            end
            if (ch == ch_r) begin
                r_ready = bp ? 1'($urandom_range(1, 0)) : 1'b1;
            end
            @(posedge clk);
            case (ch)
                ch_aw:   hs = aw_ready;
                ch_w:    hs = w_ready;
                ch_b:    hs = b_valid && b_ready;
                ch_ar:   hs = ar_ready;
                default: hs = r_valid && r_ready;
            endcase
            n++;
            #2;
        end
        b_ready = 1'b0;
        r_ready = 1'b0;
        if (!hs) begin
            abort_run(what);
        end
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input bit bp);
        logic [3:0] id;
        axi_b_t     exp_b;
        bit         ok;
        int         i;
        id = 4'($urandom);
        ok = addr < 32'(mem_bytes);
        exp_b.resp = ok ? resp_okay : resp_decerr;
        exp_b.id   = id;
        checker_i.expect_b(exp_b);
        aw = '{addr: addr, len: 8'd0, size: 3'd2, burst: burst_incr, id: id};
        w  = '{data: data, strb: strb, last: 1'b1};
        aw_valid = 1'b1;
        w_valid  = 1'b1;
        handshake_wait(ch_aw, 1'b0, "AW ready");
        aw_valid = 1'b0;
        handshake_wait(ch_w, 1'b0, "W ready");
        w_valid = 1'b0;
        if (ok) begin
            for (i = 0; i < 4; i++) begin
                if (strb[i]) begin
                    model_mem[{addr[11:2], 2'(i)}] = data[i*8 +: 8];
                end
            end
        end
        handshake_wait(ch_b, bp, "B response");
    endtask

    task automatic read_burst(input logic [31:0] addr, input int len, input logic [1:0] kind,
                              input bit bp);
        logic [3:0]  id;
        logic [31:0] a;
        axi_r_t      exp_r;
        bit          ok;
        int          i;
        id = 4'($urandom);
        a  = addr;
        for (i = 0; i <= len; i++) begin
            ok = a < 32'(mem_bytes);
            exp_r.data = ok ? model_word(a) : 32'd0;
            exp_r.resp = ok ? resp_okay : resp_decerr;
            exp_r.last = (i == len);
            exp_r.id   = id;
            checker_i.expect_r(exp_r, ok);
            a = next_beat_addr(a, len, kind);
        end
        ar = '{addr: addr, len: 8'(len), size: 3'd2, burst: kind, id: id};
        ar_valid = 1'b1;
        handshake_wait(ch_ar, 1'b0, "AR ready");
        ar_valid = 1'b0;
        for (i = 0; i <= len; i++) begin
            handshake_wait(ch_r, bp, "R beat");
        end
    endtask

    initial begin
        logic [31:0] addr;
        aw_valid = 1'b0;
        aw       = '0;
        w_valid  = 1'b0;
        w        = '0;
        b_ready  = 1'b0;
        ar_valid = 1'b0;
        ar       = '0;
        r_ready  = 1'b0;
        rst_n    = 1'b0;
        void'($urandom(32'h776aa06b));
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        checker_i.start_test("reset_state");
        repeat (3) begin
            @(posedge clk);
            checker_i.check_value("b_valid", 32'd0, 32'(b_valid));
            checker_i.check_value("r_valid", 32'd0, 32'(r_valid));
            checker_i.check_value("w_ready", 32'd0, 32'(w_ready));
            checker_i.check_value("ar_ready", 32'd0, 32'(ar_ready));
            checker_i.check_value("aw_ready", 32'd0, 32'(aw_ready));
        end
        #2;

        // Every word gets a known value before any read
        checker_i.start_test("fill");
        for (int i = 0; i < depth; i++) begin
            write_word(32'(i * 4), $urandom, 4'hf, 1'b0);
        end

        checker_i.start_test("random_writes");
        repeat (200) begin
            addr = random_addr();
            write_word(addr, $urandom, 4'($urandom), 1'b0);
            read_burst(addr, 0, burst_incr, 1'b0);
        end

        checker_i.start_test("incr_bursts");
        repeat (100) begin
            read_burst(random_addr(), $urandom_range(15, 0), burst_incr, 1'b0);
        end

        checker_i.start_test("wrap_bursts");
        repeat (100) begin
            read_burst(random_addr(), (2 << $urandom_range(3, 0)) - 1, burst_wrap, 1'b0);
        end

        // The array index aliases, so a leaked write would land on the word the low bits select
        checker_i.start_test("out_of_range");
        repeat (50) begin
            if ($urandom_range(3, 0) == 0) begin
                addr = 32'hffff_fffc;
            end else begin
                addr = 32'(mem_bytes) + ($urandom_range(4095, 0) << 2);
            end
            write_word(addr, $urandom, 4'hf, 1'b0);
            read_burst(addr & 32'h0000_0ffc, 0, burst_incr, 1'b0);
            read_burst(addr, $urandom_range(15, 0), burst_incr, 1'b0);
        end

        checker_i.start_test("back_pressure");
        repeat (150) begin
            addr = random_addr();
            case ($urandom_range(2, 0))
                0: write_word(addr, $urandom, 4'($urandom), 1'b1);
                1: read_burst(addr, $urandom_range(15, 0), burst_incr, 1'b1);
                default: read_burst(addr, (2 << $urandom_range(3, 0)) - 1, burst_wrap, 1'b1);
            endcase
        end

        repeat (4) @(posedge clk);
        if (checker_i.pending() != 0) begin
            checker_i.report("expected beats never arrived");
        end
        $display("Checks: %0d, errors: %0d", checker_i.checks, checker_i.errors);
        if (checker_i.errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/axi_bram_checker.sv
`timescale 1ns/1ps
`default_nettype none

module axi_bram_checker (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 b_valid,
    input logic                 b_ready,
    input axi_bram_pkg::axi_b_t b,
    input logic                 r_valid,
    input logic                 r_ready,
    input axi_bram_pkg::axi_r_t r
);
    import axi_bram_pkg::*;

    string test_name = "none";
    int    checks    = 0;
    int    errors    = 0;

    axi_b_t exp_b_q [$];
    axi_r_t exp_r_q [$];
    bit     data_valid_q [$];

    axi_b_t exp_b;
    axi_r_t exp_r;
    bit     data_valid;

    task automatic start_test(input string name);
        test_name = name;
    endtask

    task automatic expect_b(input axi_b_t beat);
        exp_b_q.push_back(beat);
    endtask

    // DECERR beats carry no meaningful data
    task automatic expect_r(input axi_r_t beat, input bit check_data);
        exp_r_q.push_back(beat);
        data_valid_q.push_back(check_data);
    endtask

    function automatic int pending();
        return exp_b_q.size() + exp_r_q.size();
    endfunction

    task automatic check_value(input string field, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: %s expected %h actual %h",
                     test_name, field, expected, actual);
        end
    endtask

    task automatic report(input string what);
        errors++;
        $display("Error in test %s: %s", test_name, what);
    endtask

    always @(posedge clk) begin
        if (rst_n && b_valid && b_ready) begin
            if (exp_b_q.size() == 0) begin
                report("B beat arrived with no write outstanding");
            end else begin
                exp_b = exp_b_q.pop_front();
                check_value("b.resp", 32'(exp_b.resp), 32'(b.resp));
                check_value("b.id", 32'(exp_b.id), 32'(b.id));
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && r_valid && r_ready) begin
            if (exp_r_q.size() == 0) begin
                report("R beat arrived with no read outstanding");
            end else begin
                exp_r      = exp_r_q.pop_front();
                data_valid = data_valid_q.pop_front();
                if (data_valid) begin
                    check_value("r.data", exp_r.data, r.data);
                end
                check_value("r.resp", 32'(exp_r.resp), 32'(r.resp));
                check_value("r.last", 32'(exp_r.last), 32'(r.last));
                check_value("r.id", 32'(exp_r.id), 32'(r.id));
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/axi_bram.sv
`timescale 1ns/1ps
`default_nettype none

module axi_bram #(
    parameter int DEPTH = 1024
) (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  aw_valid,
    output logic                  aw_ready,
    input  axi_bram_pkg::axi_aw_t aw,

    input  logic                  w_valid,
    output logic                  w_ready,
    input  axi_bram_pkg::axi_w_t  w,

    output logic                  b_valid,
    input  logic                  b_ready,
    output axi_bram_pkg::axi_b_t  b,

    input  logic                  ar_valid,
    output logic                  ar_ready,
    input  axi_bram_pkg::axi_ar_t ar,

    output logic                  r_valid,
    input  logic                  r_ready,
    output axi_bram_pkg::axi_r_t  r
);
    import axi_bram_pkg::*;

    burst_state_t          burst;
    logic [addr_width-1:0] next_addr;
    logic [1:0]            cur_resp;
    logic [1:0]            next_resp;

    logic [addr_width-3:0] mem_addr;
    logic                  mem_read;
    logic                  mem_write;
    logic [strb_width-1:0] mem_strb;
    logic [data_width-1:0] mem_wdata;
    logic [data_width-1:0] mem_rdata;

    axi_bram_ctrl ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .aw        (aw),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .w         (w),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .b         (b),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar        (ar),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r         (r),
        .burst     (burst),
        .next_addr (next_addr),
        .cur_resp  (cur_resp),
        .next_resp (next_resp),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_strb  (mem_strb),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    axi_burst_addr #(
        .DEPTH (DEPTH)
    ) burst_addr_i (
        .burst     (burst),
        .next_addr (next_addr),
        .cur_resp  (cur_resp),
        .next_resp (next_resp)
    );

    // Word index wraps inside the array and out-of-range beats answer DECERR
    bram_1rwm #(
        .DEPTH (DEPTH)
    ) mem_i (
        .clk   (clk),
        .addr  (mem_addr[$clog2(DEPTH)-1:0]),
        .read  (mem_read),
        .write (mem_write),
        .strb  (mem_strb),
        .wdata (mem_wdata),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

//--- hw/axi_bram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module axi_bram_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                aw_valid,
    output logic                                aw_ready,
    input  axi_bram_pkg::axi_aw_t               aw,

    input  logic                                w_valid,
    output logic                                w_ready,
    input  axi_bram_pkg::axi_w_t                w,

    output logic                                b_valid,
    input  logic                                b_ready,
    output axi_bram_pkg::axi_b_t                b,

    input  logic                                ar_valid,
    output logic                                ar_ready,
    input  axi_bram_pkg::axi_ar_t               ar,

    output logic                                r_valid,
    input  logic                                r_ready,
    output axi_bram_pkg::axi_r_t                r,

    output axi_bram_pkg::burst_state_t          burst,
    input  logic [axi_bram_pkg::addr_width-1:0] next_addr,
    input  logic [1:0]                          cur_resp,
    input  logic [1:0]                          next_resp,

    output logic [axi_bram_pkg::addr_width-3:0] mem_addr,
    output logic                                mem_read,
    output logic                                mem_write,
    output logic [axi_bram_pkg::strb_width-1:0] mem_strb,
    output logic [axi_bram_pkg::data_width-1:0] mem_wdata,
    input  logic [axi_bram_pkg::data_width-1:0] mem_rdata
);
    import axi_bram_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wdata,
        st_wresp,
        st_rburst
    } state_t;

    state_t              state;
    burst_state_t        burst_q;
    logic [id_width-1:0] id_q;
    logic [1:0]          resp_q;

    logic aw_hs;
    logic w_hs;
    logic b_hs;
    logic ar_hs;
    logic r_hs;
    logic r_last;

    // A waiting write wins over a waiting read
    assign aw_ready = (state == st_idle) && aw_valid;
    assign ar_ready = (state == st_idle) && !aw_valid && ar_valid;
    assign w_ready  = (state == st_wdata);
    assign b_valid  = (state == st_wresp);
    assign r_valid  = (state == st_rburst);

    assign aw_hs = aw_valid && aw_ready;
    assign w_hs  = w_valid && w_ready;
    assign b_hs  = b_valid && b_ready;
    assign ar_hs = ar_valid && ar_ready;
    assign r_hs  = r_valid && r_ready;

    assign r_last = (burst_q.remaining == 9'd0);

    // In idle the address unit sees the request on offer,
    // so cur_resp is the range check of the incoming address
    always_comb begin
        burst = burst_q;
        if (state == st_idle) begin
            if (aw_valid) begin
                burst.addr      = aw.addr;
                burst.len       = aw.len;
                burst.burst     = aw.burst;
                burst.remaining = {1'b0, aw.len};
            end else begin
                burst.addr      = ar.addr;
                burst.len       = ar.len;
                burst.burst     = ar.burst;
                burst.remaining = {1'b0, ar.len};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (aw_hs) begin
                        state <= st_wdata;
                    end else if (ar_hs) begin
                        state <= st_rburst;
                    end
                end
                st_wdata: begin
                    if (w_hs) begin
                        state <= st_wresp;
                    end
                end
                st_wresp: begin
                    if (b_hs) begin
                        state <= st_idle;
                    end
                end
                st_rburst: begin
                    if (r_hs && r_last) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs || ar_hs) begin
            burst_q <= burst;
            resp_q  <= cur_resp;
            id_q    <= aw_hs ? aw.id : ar.id;
        end else if (r_hs) begin
            // Step to the beat whose read is issued this cycle
            burst_q.addr      <= next_addr;
            burst_q.remaining <= burst_q.remaining - 9'd1;
            resp_q            <= next_resp;
        end
    end

    // One read runs ahead of the beat on the R channel
    assign mem_read  = ar_hs || (r_hs && !r_last);
    assign mem_write = w_hs && (resp_q == resp_okay);
    assign mem_addr  = r_hs ? next_addr[addr_width-1:2] : burst.addr[addr_width-1:2];
    assign mem_strb  = w.strb;
    assign mem_wdata = w.data;

    assign b = '{resp: resp_q, id: id_q};
    assign r = '{data: mem_rdata, resp: resp_q, last: r_last, id: id_q};

    // Only single-beat full-word writes
    aw_single_word: assert property (@(posedge clk) disable iff (!rst_n)
        aw_hs |-> (aw.len == 8'd0) && (aw.size == 3'd2));

    w_single_beat: assert property (@(posedge clk) disable iff (!rst_n)
        w_hs |-> w.last);

    ar_supported: assert property (@(posedge clk) disable iff (!rst_n)
        ar_hs |-> ((ar.burst == burst_incr) || (ar.burst == burst_wrap)) && (ar.size == 3'd2));

    // R beat must hold under back-pressure
    r_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (r_valid && !r_ready) |=> r_valid && $stable(r));

endmodule

`default_nettype wire

//--- hw/axi_burst_addr.sv
`timescale 1ns/1ps
`default_nettype none

module axi_burst_addr #(
    parameter int DEPTH = 1024
) (
    input  axi_bram_pkg::burst_state_t          burst,
    output logic [axi_bram_pkg::addr_width-1:0] next_addr,
    output logic [1:0]                          cur_resp,
    output logic [1:0]                          next_resp
);
    import axi_bram_pkg::*;

    // One extra bit so the byte size never overflows the compare
    localparam logic [addr_width:0] mem_bytes = (addr_width + 1)'(DEPTH) << 2;

    logic [addr_width-1:0] incr_addr;
    logic [addr_width-1:0] wrap_mask;

    assign incr_addr = burst.addr + addr_width'(4);

    // len 1, 3, 7, 15 gives a block of 2, 4, 8, 16 words
    assign wrap_mask = {{(addr_width - 10){1'b0}}, burst.len, 2'b11};

    always_comb begin
        if (burst.burst == burst_wrap) begin
            next_addr = (burst.addr & ~wrap_mask) | (incr_addr & wrap_mask);
        end else begin
            next_addr = incr_addr;
        end
    end

    assign cur_resp  = ({1'b0, burst.addr} < mem_bytes) ? resp_okay : resp_decerr;
    assign next_resp = ({1'b0, next_addr} < mem_bytes) ? resp_okay : resp_decerr;

endmodule

`default_nettype wire

//--- hw/bram_1rwm.sv
`timescale 1ns/1ps
`default_nettype none

module bram_1rwm #(
    parameter int DEPTH = 1024
) (
    input  logic                                clk,
    input  logic [$clog2(DEPTH)-1:0]            addr,
    input  logic                                read,
    input  logic                                write,
    input  logic [axi_bram_pkg::strb_width-1:0] strb,
    input  logic [axi_bram_pkg::data_width-1:0] wdata,
    output logic [axi_bram_pkg::data_width-1:0] rdata
);
    import axi_bram_pkg::*;

    logic [data_width-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (write) begin
            for (int i = 0; i < strb_width; i++) begin
                if (strb[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
        // Output register holds between reads
        if (read) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- hw/axi_bram_pkg.sv
`default_nettype none

package axi_bram_pkg;

    // Bus widths
    localparam int addr_width = 32;
    localparam int id_width   = 4;
    localparam int data_width = 32;
    localparam int strb_width = data_width / 8;

    // Response and burst encodings
    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_decerr = 2'b11;
    localparam logic [1:0] burst_incr  = 2'b01;
    localparam logic [1:0] burst_wrap  = 2'b10;

    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        logic [1:0]            burst;
        logic [id_width-1:0]   id;
    } axi_aw_t;

    typedef axi_aw_t axi_ar_t;

    typedef struct packed {
        logic [data_width-1:0] data;
        logic [strb_width-1:0] strb;
        logic                  last;
    } axi_w_t;

    typedef struct packed {
        logic [1:0]          resp;
        logic [id_width-1:0] id;
    } axi_b_t;

    typedef struct packed {
        logic [data_width-1:0] data;
        logic [1:0]            resp;
        logic                  last;
        logic [id_width-1:0]   id;
    } axi_r_t;

    // Remaining counts R beats still to go after the current one
    typedef struct packed {
        logic [addr_width-1:0] addr;
        logic [7:0]            len;
        logic [1:0]            burst;
        logic [8:0]            remaining;
    } burst_state_t;

endpackage

`default_nettype wire
